/* hw/reindeer_pkg.sv */
/*
 * shared widths, instruction field positions and reset pc
 * opcode and alu operation enums for the integer pipeline
 */

`default_nettype none

package reindeer_pkg;

    // ------------------------------------------------------------
    // widths
    // ------------------------------------------------------------
    localparam int XLEN          = 32;
    localparam int PC_BITWIDTH   = 32;
    localparam int REG_ADDR_BITS = 5;
    // word address from pc bits 13:2
    localparam int MEM_ADDR_BITS = 12;

    // instruction queue
    localparam int IBUF_DEPTH    = 4;
    localparam int IBUF_PTR_BITS = 2;

    // ------------------------------------------------------------
    // instruction fields
    // ------------------------------------------------------------
    localparam int OPCODE_LSB  = 0;
    localparam int RD_LSB      = 7;
    localparam int FUNCT3_LSB  = 12;
    localparam int RS1_LSB     = 15;
    localparam int RS2_LSB     = 20;
    localparam int FUNCT7_LSB  = 25;

    localparam logic [XLEN-1:0] WFI_WORD = 32'h1050_0073;

    localparam logic [PC_BITWIDTH-1:0] RESET_PC = '0;

    // ------------------------------------------------------------
    // encodings
    // ------------------------------------------------------------
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

endpackage

`default_nettype wire

/* hw/reindeer_fetch.sv */
/*
 * instruction fetch: program counter, code memory read sequencing
 * and push of fetched words into the instruction queue
 */

`timescale 1ns/10ps
`default_nettype none

module reindeer_fetch (
    input  wire                                       clk,
    input  wire                                       rst_i,
    input  wire                                       start_i,
    input  wire  [reindeer_pkg::PC_BITWIDTH-1:0]      start_address_i,
    input  wire                                       paused_i,
    output logic                                      code_read_en_o,
    output logic [reindeer_pkg::MEM_ADDR_BITS-1:0]    code_addr_o,
    input  wire  [reindeer_pkg::XLEN-1:0]             code_read_data_i,
    input  wire                                       code_read_ack_i,
    output logic                                      valid_o,
    output logic [reindeer_pkg::PC_BITWIDTH-1:0]      pc_o,
    output logic [reindeer_pkg::XLEN-1:0]             ir_o,
    input  wire                                       ready_i,
    output logic                                      flush_o
);

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_READ,
        FETCH_PUSH
    } fetch_state_e;

    fetch_state_e                                 state_q;
    logic [reindeer_pkg::PC_BITWIDTH-1:0]         pc_q;
    logic [reindeer_pkg::PC_BITWIDTH-1:0]         pc_next;
    logic [reindeer_pkg::MEM_ADDR_BITS-1:0]       addr_q;
    logic [reindeer_pkg::XLEN-1:0]                ir_q;
    logic                                         drop_q;
    logic                                         start_accept;

    assign start_accept   = start_i & paused_i;
    assign flush_o        = start_accept;
    assign pc_next        = pc_q + 32'd4;

    assign code_read_en_o = (state_q == FETCH_READ);
    assign code_addr_o    = addr_q;
    assign valid_o        = (state_q == FETCH_PUSH);
    assign pc_o           = pc_q;
    assign ir_o           = ir_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= FETCH_IDLE;
            pc_q    <= reindeer_pkg::RESET_PC;
            drop_q  <= 1'b0;
        end else begin
            case (state_q)
                FETCH_IDLE: begin
                    if (start_accept) begin
                        pc_q    <= start_address_i;
                        addr_q  <= start_address_i[reindeer_pkg::MEM_ADDR_BITS+1:2];
                        state_q <= FETCH_READ;
                    end
                end
                FETCH_READ: begin
                    if (code_read_ack_i) begin
                        if (drop_q || start_accept) begin
                            // drop the stale word and read from the restart address
                            drop_q <= 1'b0;
                            if (start_accept) begin
                                pc_q   <= start_address_i;
                                addr_q <= start_address_i[reindeer_pkg::MEM_ADDR_BITS+1:2];
                            end else begin
                                addr_q <= pc_q[reindeer_pkg::MEM_ADDR_BITS+1:2];
                            end
                        end else begin
                            ir_q    <= code_read_data_i;
                            state_q <= FETCH_PUSH;
                        end
                    end else if (start_accept) begin
                        // the request must stay put until its ack
                        pc_q   <= start_address_i;
                        drop_q <= 1'b1;
                    end
                end
                default: begin
                    if (start_accept) begin
                        pc_q    <= start_address_i;
                        addr_q  <= start_address_i[reindeer_pkg::MEM_ADDR_BITS+1:2];
                        state_q <= FETCH_READ;
                    end else if (ready_i) begin
                        pc_q    <= pc_next;
                        addr_q  <= pc_next[reindeer_pkg::MEM_ADDR_BITS+1:2];
                        state_q <= paused_i ? FETCH_IDLE : FETCH_READ;
                    end
                end
            endcase
        end
    end

    // request held level until acked
    a_req_stable: assert property (@(posedge clk) disable iff (rst_i)
        code_read_en_o && !code_read_ack_i |=> code_read_en_o && $stable(code_addr_o));

endmodule

`default_nettype wire

/* hw/reindeer_ibuf.sv */
/*
 * instruction queue between fetch and execute
 * circular buffer with valid/ready on both sides and flush
 */

`timescale 1ns/10ps
`default_nettype none

module reindeer_ibuf (
    input  wire                                       clk,
    input  wire                                       rst_i,
    input  wire                                       flush_i,
    input  wire                                       push_valid_i,
    input  wire  [reindeer_pkg::PC_BITWIDTH-1:0]      push_pc_i,
    input  wire  [reindeer_pkg::XLEN-1:0]             push_ir_i,
    output logic                                      push_ready_o,
    output logic                                      pop_valid_o,
    output logic [reindeer_pkg::PC_BITWIDTH-1:0]      pop_pc_o,
    output logic [reindeer_pkg::XLEN-1:0]             pop_ir_o,
    input  wire                                       pop_ready_i
);

    logic [reindeer_pkg::PC_BITWIDTH-1:0]   pc_mem [reindeer_pkg::IBUF_DEPTH];
    logic [reindeer_pkg::XLEN-1:0]          ir_mem [reindeer_pkg::IBUF_DEPTH];
    logic [reindeer_pkg::IBUF_PTR_BITS-1:0] wr_ptr_q;
    logic [reindeer_pkg::IBUF_PTR_BITS-1:0] rd_ptr_q;
    logic [reindeer_pkg::IBUF_PTR_BITS:0]   count_q;
    logic                                   do_push;
    logic                                   do_pop;

    // a full queue still takes a word when the head leaves in the same cycle
    assign push_ready_o = (count_q != reindeer_pkg::IBUF_DEPTH) | pop_ready_i;
    assign pop_valid_o  = (count_q != '0);
    assign pop_pc_o     = pc_mem[rd_ptr_q];
    assign pop_ir_o     = ir_mem[rd_ptr_q];

    assign do_push = push_valid_i & push_ready_o;
    assign do_pop  = pop_valid_o & pop_ready_i;

    always_ff @(posedge clk) begin
        if (do_push) begin
            pc_mem[wr_ptr_q] <= push_pc_i;
            ir_mem[wr_ptr_q] <= push_ir_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + {2'b00, do_push} - {2'b00, do_pop};
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (rst_i)
        count_q <= reindeer_pkg::IBUF_DEPTH);

endmodule

`default_nettype wire

/* hw/reindeer_reg_file.sv */
/*
 * integer register file, 32 x 32
 * two combinational read ports, one write port, x0 reads zero
 */

`timescale 1ns/10ps
`default_nettype none

module reindeer_reg_file (
    input  wire                                       clk,
    input  wire                                       rst_i,
    input  wire  [reindeer_pkg::REG_ADDR_BITS-1:0]    rs1_addr_i,
    input  wire  [reindeer_pkg::REG_ADDR_BITS-1:0]    rs2_addr_i,
    output logic [reindeer_pkg::XLEN-1:0]             rs1_data_o,
    output logic [reindeer_pkg::XLEN-1:0]             rs2_data_o,
    input  wire                                       we_i,
    input  wire  [reindeer_pkg::REG_ADDR_BITS-1:0]    rd_addr_i,
    input  wire  [reindeer_pkg::XLEN-1:0]             rd_data_i
);

    // x0 has no storage
    logic [reindeer_pkg::XLEN-1:0] regs_q [1:31];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (rd_addr_i != '0)) begin
            regs_q[rd_addr_i] <= rd_data_i;
        end
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

`default_nettype wire

/* hw/reindeer_exec.sv */
/*
 * execute stage: decode, alu, register write-back,
 * wfi pause flag and the retire report
 */

`timescale 1ns/10ps
`default_nettype none

module reindeer_exec (
    input  wire                                       clk,
    input  wire                                       rst_i,
    input  wire                                       start_i,
    input  wire                                       valid_i,
    input  wire  [reindeer_pkg::PC_BITWIDTH-1:0]      pc_i,
    input  wire  [reindeer_pkg::XLEN-1:0]             ir_i,
    output logic                                      ready_o,
    output logic [reindeer_pkg::REG_ADDR_BITS-1:0]    rs1_addr_o,
    output logic [reindeer_pkg::REG_ADDR_BITS-1:0]    rs2_addr_o,
    input  wire  [reindeer_pkg::XLEN-1:0]             rs1_data_i,
    input  wire  [reindeer_pkg::XLEN-1:0]             rs2_data_i,
    output logic                                      rd_we_o,
    output logic [reindeer_pkg::REG_ADDR_BITS-1:0]    rd_addr_o,
    output logic [reindeer_pkg::XLEN-1:0]             rd_data_o,
    output logic                                      paused_o,
    output logic                                      retire_valid_o,
    output logic [reindeer_pkg::PC_BITWIDTH-1:0]      retire_pc_o,
    output logic [reindeer_pkg::XLEN-1:0]             retire_ir_o,
    output logic                                      retire_rd_we_o,
    output logic [reindeer_pkg::REG_ADDR_BITS-1:0]    retire_rd_o,
    output logic [reindeer_pkg::XLEN-1:0]             retire_rd_data_o
);

    reindeer_pkg::opcode_e          opcode;
    reindeer_pkg::alu_op_e          alu_op;
    logic [2:0]                     funct3;
    logic [6:0]                     funct7;
    logic [reindeer_pkg::XLEN-1:0]  imm_i;
    logic [reindeer_pkg::XLEN-1:0]  imm_u;
    logic [reindeer_pkg::XLEN-1:0]  op_b;
    logic [reindeer_pkg::XLEN-1:0]  alu_out;
    logic                           writes_rd;
    logic                           is_wfi;
    logic                           accept;
    logic                           paused_q;

    // ------------------------------------------------------------
    // decode
    // ------------------------------------------------------------
    assign opcode     = reindeer_pkg::opcode_e'(ir_i[reindeer_pkg::OPCODE_LSB +: 7]);
    assign funct3     = ir_i[reindeer_pkg::FUNCT3_LSB +: 3];
    assign funct7     = ir_i[reindeer_pkg::FUNCT7_LSB +: 7];
    assign rs1_addr_o = ir_i[reindeer_pkg::RS1_LSB +: reindeer_pkg::REG_ADDR_BITS];
    assign rs2_addr_o = ir_i[reindeer_pkg::RS2_LSB +: reindeer_pkg::REG_ADDR_BITS];
    assign rd_addr_o  = ir_i[reindeer_pkg::RD_LSB +: reindeer_pkg::REG_ADDR_BITS];

    assign imm_i = {{20{ir_i[31]}}, ir_i[31:20]};
    assign imm_u = {ir_i[31:12], 12'h000};
    assign op_b  = (opcode == reindeer_pkg::OPC_OP) ? rs2_data_i : imm_i;

    always_comb begin
        case (funct3)
            3'd0: alu_op = ((opcode == reindeer_pkg::OPC_OP) && funct7[5]) ?
                           reindeer_pkg::ALU_SUB : reindeer_pkg::ALU_ADD;
            3'd1: alu_op = reindeer_pkg::ALU_SLL;
            3'd2: alu_op = reindeer_pkg::ALU_SLT;
            3'd3: alu_op = reindeer_pkg::ALU_SLTU;
            3'd4: alu_op = reindeer_pkg::ALU_XOR;
            3'd5: alu_op = funct7[5] ? reindeer_pkg::ALU_SRA : reindeer_pkg::ALU_SRL;
            3'd6: alu_op = reindeer_pkg::ALU_OR;
            default: alu_op = reindeer_pkg::ALU_AND;
        endcase
    end

    // ------------------------------------------------------------
    // alu and result select
    // ------------------------------------------------------------
    always_comb begin
        case (alu_op)
            reindeer_pkg::ALU_SUB:  alu_out = rs1_data_i - op_b;
            reindeer_pkg::ALU_SLL:  alu_out = rs1_data_i << op_b[4:0];
            reindeer_pkg::ALU_SLT:  alu_out = {31'd0, $signed(rs1_data_i) < $signed(op_b)};
            reindeer_pkg::ALU_SLTU: alu_out = {31'd0, rs1_data_i < op_b};
            reindeer_pkg::ALU_XOR:  alu_out = rs1_data_i ^ op_b;
            reindeer_pkg::ALU_SRL:  alu_out = rs1_data_i >> op_b[4:0];
            reindeer_pkg::ALU_SRA:  alu_out = $unsigned($signed(rs1_data_i) >>> op_b[4:0]);
            reindeer_pkg::ALU_OR:   alu_out = rs1_data_i | op_b;
            reindeer_pkg::ALU_AND:  alu_out = rs1_data_i & op_b;
            default:                alu_out = rs1_data_i + op_b;
        endcase
    end

    always_comb begin
        case (opcode)
            reindeer_pkg::OPC_LUI:   rd_data_o = imm_u;
            reindeer_pkg::OPC_AUIPC: rd_data_o = pc_i + imm_u;
            default:                 rd_data_o = alu_out;
        endcase
    end

    assign writes_rd = (opcode == reindeer_pkg::OPC_LUI) || (opcode == reindeer_pkg::OPC_AUIPC) ||
                       (opcode == reindeer_pkg::OPC_OP_IMM) || (opcode == reindeer_pkg::OPC_OP);
    assign is_wfi    = (opcode == reindeer_pkg::OPC_SYSTEM) && (ir_i == reindeer_pkg::WFI_WORD);

    assign ready_o  = ~paused_q;
    assign accept   = valid_i & ready_o;
    assign rd_we_o  = accept & writes_rd & (rd_addr_o != '0);
    assign paused_o = paused_q;

    // ------------------------------------------------------------
    // pause flag and retire report
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            paused_q       <= 1'b1;
            retire_valid_o <= 1'b0;
        end else begin
            if (accept && is_wfi) begin
                paused_q <= 1'b1;
            end else if (start_i && paused_q) begin
                paused_q <= 1'b0;
            end
            retire_valid_o <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            retire_pc_o      <= pc_i;
            retire_ir_o      <= ir_i;
            retire_rd_we_o   <= rd_we_o;
            retire_rd_o      <= rd_addr_o;
            retire_rd_data_o <= rd_data_o;
        end
    end

    // a stalled instruction holds until taken or flushed by start
    a_in_held: assert property (@(posedge clk) disable iff (rst_i)
        valid_i && !ready_o && !start_i |=> valid_i && $stable(pc_i) && $stable(ir_i));

endmodule

`default_nettype wire

/* hw/reindeer_core.sv */
/*
 * top level of the integer pipeline
 * fetch, instruction queue, execute and register file
 */

`timescale 1ns/10ps
`default_nettype none

module reindeer_core (
    input  wire                                       clk,
    input  wire                                       rst_i,
    input  wire                                       start_i,
    input  wire  [reindeer_pkg::PC_BITWIDTH-1:0]      start_address_i,
    output logic                                      code_read_en_o,
    output logic [reindeer_pkg::MEM_ADDR_BITS-1:0]    code_addr_o,
    input  wire  [reindeer_pkg::XLEN-1:0]             code_read_data_i,
    input  wire                                       code_read_ack_i,
    output logic                                      processor_paused_o,
    output logic                                      retire_valid_o,
    output logic [reindeer_pkg::PC_BITWIDTH-1:0]      retire_pc_o,
    output logic [reindeer_pkg::XLEN-1:0]             retire_ir_o,
    output logic                                      retire_rd_we_o,
    output logic [reindeer_pkg::REG_ADDR_BITS-1:0]    retire_rd_o,
    output logic [reindeer_pkg::XLEN-1:0]             retire_rd_data_o
);

    // ------------------------------------------------------------
    // pipeline wires
    // ------------------------------------------------------------
    logic                                     fetch_valid;
    logic                                     fetch_ready;
    logic [reindeer_pkg::PC_BITWIDTH-1:0]     fetch_pc;
    logic [reindeer_pkg::XLEN-1:0]            fetch_ir;
    logic                                     fetch_flush;

    logic                                     ibuf_valid;
    logic                                     ibuf_ready;
    logic [reindeer_pkg::PC_BITWIDTH-1:0]     ibuf_pc;
    logic [reindeer_pkg::XLEN-1:0]            ibuf_ir;

    logic [reindeer_pkg::REG_ADDR_BITS-1:0]   rs1_addr;
    logic [reindeer_pkg::REG_ADDR_BITS-1:0]   rs2_addr;
    logic [reindeer_pkg::XLEN-1:0]            rs1_data;
    logic [reindeer_pkg::XLEN-1:0]            rs2_data;
    logic                                     rd_we;
    logic [reindeer_pkg::REG_ADDR_BITS-1:0]   rd_addr;
    logic [reindeer_pkg::XLEN-1:0]            rd_data;

    reindeer_fetch u_fetch (
        .clk              (clk),
        .rst_i            (rst_i),
        .start_i          (start_i),
        .start_address_i  (start_address_i),
        .paused_i         (processor_paused_o),
        .code_read_en_o   (code_read_en_o),
        .code_addr_o      (code_addr_o),
        .code_read_data_i (code_read_data_i),
        .code_read_ack_i  (code_read_ack_i),
        .valid_o          (fetch_valid),
        .pc_o             (fetch_pc),
        .ir_o             (fetch_ir),
        .ready_i          (fetch_ready),
        .flush_o          (fetch_flush)
    );

    reindeer_ibuf u_ibuf (
        .clk          (clk),
        .rst_i        (rst_i),
        .flush_i      (fetch_flush),
        .push_valid_i (fetch_valid),
        .push_pc_i    (fetch_pc),
        .push_ir_i    (fetch_ir),
        .push_ready_o (fetch_ready),
        .pop_valid_o  (ibuf_valid),
        .pop_pc_o     (ibuf_pc),
        .pop_ir_o     (ibuf_ir),
        .pop_ready_i  (ibuf_ready)
    );

    reindeer_exec u_exec (
        .clk              (clk),
        .rst_i            (rst_i),
        .start_i          (start_i),
        .valid_i          (ibuf_valid),
        .pc_i             (ibuf_pc),
        .ir_i             (ibuf_ir),
        .ready_o          (ibuf_ready),
        .rs1_addr_o       (rs1_addr),
        .rs2_addr_o       (rs2_addr),
        .rs1_data_i       (rs1_data),
        .rs2_data_i       (rs2_data),
        .rd_we_o          (rd_we),
        .rd_addr_o        (rd_addr),
        .rd_data_o        (rd_data),
        .paused_o         (processor_paused_o),
        .retire_valid_o   (retire_valid_o),
        .retire_pc_o      (retire_pc_o),
        .retire_ir_o      (retire_ir_o),
        .retire_rd_we_o   (retire_rd_we_o),
        .retire_rd_o      (retire_rd_o),
        .retire_rd_data_o (retire_rd_data_o)
    );

    reindeer_reg_file u_reg_file (
        .clk        (clk),
        .rst_i      (rst_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (rd_we),
        .rd_addr_i  (rd_addr),
        .rd_data_i  (rd_data)
    );

endmodule

`default_nettype wire

/* testbench/tb_model.svh */
/*
 * random program generator and reference model for the
 * supported integer instructions
 */

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam logic [31:0] WFI_INSTR = 32'h1050_0073;

// architectural register state as the model sees it
logic [31:0] model_regs [32];

function automatic void reset_model();
    for (int i = 0; i < 32; i++) begin
        model_regs[i] = 32'h0;
    end
endfunction

function automatic logic [31:0] random_instr();
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    int          kind;
    r    = $urandom;
    rd   = 5'($urandom_range(0, 15));
    rs1  = 5'($urandom_range(0, 15));
    rs2  = 5'($urandom_range(0, 15));
    f3   = 3'($urandom_range(0, 7));
    f7   = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
    // shift immediates carry funct7 in the upper bits
    imm  = (f3 == 3'd1 || f3 == 3'd5) ? {f7, rs2} : r[31:20];
    kind = $urandom_range(0, 11);
    case (kind)
        0:       return {r[31:12], rd, 7'h37};
        1:       return {r[31:12], rd, 7'h17};
        2, 3, 4, 5, 6: return {imm, rs1, f3, rd, 7'h13};
        7, 8, 9, 10:   return {f7, rs2, rs1, f3, rd, 7'h33};
        // load, store, branch and jal retire as no-ops
        default: begin
            case (r[1:0])
                2'd0:    return {r[31:7], 7'h03};
                2'd1:    return {r[31:7], 7'h23};
                2'd2:    return {r[31:7], 7'h63};
                default: return {r[31:7], 7'h6f};
            endcase
        end
    endcase
endfunction

function automatic void model_step(input logic [31:0] pc, input logic [31:0] ir,
                                   output logic we, output logic [4:0] rd,
                                   output logic [31:0] val);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  sh;
    opc = ir[6:0];
    f3  = ir[14:12];
    rd  = ir[11:7];
    a   = model_regs[ir[19:15]];
    b   = (opc == 7'h33) ? model_regs[ir[24:20]] : {{20{ir[31]}}, ir[31:20]};
    sh  = b[4:0];
    we  = 1'b1;
    val = 32'h0;
    case (opc)
        7'h37: val = {ir[31:12], 12'h000};
        7'h17: val = pc + {ir[31:12], 12'h000};
        7'h13, 7'h33: begin
            case (f3)
                3'd0: begin
                    if (opc == 7'h33 && ir[30]) val = a - b;
                    else val = a + b;
                end
                3'd1: val = a << sh;
                3'd2: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3: val = (a < b) ? 32'd1 : 32'd0;
                3'd4: val = a ^ b;
                3'd5: begin
                    if (ir[30]) val = $signed(a) >>> sh;
                    else val = a >> sh;
                end
                3'd6: val = a | b;
                default: val = a & b;
            endcase
        end
        default: we = 1'b0;
    endcase
    if (rd == 5'd0) we = 1'b0;
    if (we) model_regs[rd] = val;
endfunction

`endif

/* testbench/tb_reindeer_core.sv */
/*
 * testbench for the integer pipeline: clock, reset, code memory
 * with random ack latency, two random programs, retire checks
 */

`timescale 1ns/10ps
`default_nettype none

module tb_reindeer_core;

    localparam logic [31:0] SEED       = 32'h2d70_4f3d;
    localparam logic [31:0] PROG1_ADDR = 32'h0000_0040;
    localparam logic [31:0] PROG2_ADDR = 32'h0000_2000;
    localparam int          PROG_LEN   = 60;
    localparam int          WAIT_LIMIT = 5000;

    logic        clk;
    logic        rst_i;
    logic        start_i;
    logic [31:0] start_address_i;
    logic        code_read_en_o;
    logic [11:0] code_addr_o;
    logic [31:0] code_read_data_i;
    logic        code_read_ack_i;
    logic        processor_paused_o;
    logic        retire_valid_o;
    logic [31:0] retire_pc_o;
    logic [31:0] retire_ir_o;
    logic        retire_rd_we_o;
    logic [4:0]  retire_rd_o;
    logic [31:0] retire_rd_data_o;

    logic [31:0] code_mem [4096];
    logic [31:0] exp_pc;
    logic        running;
    logic        timed_out;
    logic        burst_mode;
    logic        mem_waiting;
    int          mem_wait_left;
    int          retired;
    int          checks;
    int          errors;

    `include "tb_model.svh"

    reindeer_core u_reindeer_core (
        .clk                (clk),
        .rst_i              (rst_i),
        .start_i            (start_i),
        .start_address_i    (start_address_i),
        .code_read_en_o     (code_read_en_o),
        .code_addr_o        (code_addr_o),
        .code_read_data_i   (code_read_data_i),
        .code_read_ack_i    (code_read_ack_i),
        .processor_paused_o (processor_paused_o),
        .retire_valid_o     (retire_valid_o),
        .retire_pc_o        (retire_pc_o),
        .retire_ir_o        (retire_ir_o),
        .retire_rd_we_o     (retire_rd_we_o),
        .retire_rd_o        (retire_rd_o),
        .retire_rd_data_o   (retire_rd_data_o)
    );

    always #50 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    // ------------------------------------------------------------
    // code memory
    // ------------------------------------------------------------
    function automatic int pick_delay();
        if (!burst_mode) return $urandom_range(0, 5);
        // mostly back-to-back acks with the odd slow one
        return ($urandom_range(0, 3) == 0) ? $urandom_range(3, 5) : 0;
    endfunction

    task automatic load_program(input logic [31:0] base, input int len);
        for (int i = 0; i < len; i++) begin
            code_mem[base[13:2] + 12'(i)] = random_instr();
        end
        code_mem[base[13:2] + 12'(len)] = WFI_INSTR;
    endtask

    always @(posedge clk) begin
        #1;
        if (rst_i) begin
            code_read_ack_i = 1'b0;
            mem_waiting     = 1'b0;
        end else begin
            if (code_read_ack_i) begin
                code_read_ack_i = 1'b0;
                mem_waiting     = 1'b0;
            end
            if (code_read_en_o && !mem_waiting) begin
                mem_waiting   = 1'b1;
                mem_wait_left = pick_delay();
            end
            if (mem_waiting) begin
                if (mem_wait_left == 0) begin
                    code_read_ack_i  = 1'b1;
                    code_read_data_i = code_mem[code_addr_o];
                end else begin
                    mem_wait_left--;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // retire monitor sampled at mid-cycle
    // ------------------------------------------------------------
    always @(negedge clk) begin : retire_check
        logic        exp_we;
        logic [4:0]  exp_rd;
        logic [31:0] exp_data;
        logic [31:0] exp_ir;
        if (!rst_i && retire_valid_o) begin
            if (!running) begin
                errors++;
                $display("Instruction retired while the core should be halted, pc 0x%08h",
                         retire_pc_o);
            end else begin
                exp_ir = code_mem[exp_pc[13:2]];
                model_step(exp_pc, exp_ir, exp_we, exp_rd, exp_data);
                check_value("retire_pc_o", retire_pc_o, exp_pc);
                check_value("retire_ir_o", retire_ir_o, exp_ir);
                check_value("retire_rd_we_o", {31'd0, retire_rd_we_o}, {31'd0, exp_we});
                check_value("retire_rd_o", {27'd0, retire_rd_o}, {27'd0, exp_rd});
                if (exp_we) begin
                    check_value("retire_rd_data_o", retire_rd_data_o, exp_data);
                end
                exp_pc = exp_pc + 32'd4;
                retired++;
                if (exp_ir == WFI_INSTR) begin
                    check_value("processor_paused_o", {31'd0, processor_paused_o}, 32'd1);
                    running = 1'b0;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // one program from start through wfi and the quiet window
    // ------------------------------------------------------------
    task automatic run_program(input logic [31:0] addr, input int len);
        int cyc;
        cyc = 0;
        while (!processor_paused_o && cyc < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cyc++;
        end
        if (!processor_paused_o) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout: core never paused before start at 0x%08h", addr);
            return;
        end
        start_address_i = addr;
        start_i         = 1'b1;
        exp_pc          = addr;
        retired         = 0;
        running         = 1'b1;
        @(posedge clk);
        #1;
        start_i = 1'b0;
        check_value("processor_paused_o", {31'd0, processor_paused_o}, 32'd0);
        check_value("code_read_en_o", {31'd0, code_read_en_o}, 32'd1);
        check_value("code_addr_o", {20'd0, code_addr_o}, {20'd0, addr[13:2]});
        cyc = 0;
        while (running && cyc < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cyc++;
        end
        if (running) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout: WFI of the program at 0x%08h never retired", addr);
            return;
        end
        check_value("retired instruction count", 32'(retired), 32'(len + 1));
        // nothing may retire in this window
        repeat (200) @(posedge clk);
        #1;
        check_value("processor_paused_o", {31'd0, processor_paused_o}, 32'd1);
    endtask

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    initial begin
        clk              = 1'b0;
        rst_i            = 1'b1;
        start_i          = 1'b0;
        start_address_i  = 32'h0;
        code_read_ack_i  = 1'b0;
        code_read_data_i = 32'h0;
        running          = 1'b0;
        timed_out        = 1'b0;
        burst_mode       = 1'b0;
        mem_waiting      = 1'b0;
        mem_wait_left    = 0;
        checks           = 0;
        errors           = 0;
        void'($urandom(SEED));

        // unused words hold an unsupported opcode tagged with their address
        for (int a = 0; a < 4096; a++) begin
            code_mem[a] = {a[11:0], 13'h0, 7'h7f};
        end
        reset_model();
        load_program(PROG1_ADDR, PROG_LEN);
        load_program(PROG2_ADDR, PROG_LEN);

        repeat (16) @(posedge clk);
        #1;
        rst_i = 1'b0;
        @(posedge clk);
        #1;
        check_value("processor_paused_o", {31'd0, processor_paused_o}, 32'd1);
        check_value("code_read_en_o", {31'd0, code_read_en_o}, 32'd0);
        check_value("retire_valid_o", {31'd0, retire_valid_o}, 32'd0);

        run_program(PROG1_ADDR, PROG_LEN);
        if (!timed_out) begin
            // second run keeps the registers of the first
            burst_mode = 1'b1;
            run_program(PROG2_ADDR, PROG_LEN);
        end
        finish_run();
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+testbench
hw/reindeer_pkg.sv
hw/reindeer_fetch.sv
hw/reindeer_ibuf.sv
hw/reindeer_reg_file.sv
hw/reindeer_exec.sv
hw/reindeer_core.sv
testbench/tb_reindeer_core.sv

/* Makefile */
# Verilator build and run of the reindeer core testbench

VERILATOR ?= verilator
TOP       ?= tb_reindeer_core
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard testbench/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
